// File: jtag_master.f
+incdir+hw
hw/jtag_bus_pkg.sv
hw/jtag_tap_pkg.sv
hw/jtag_master_regs.sv
hw/jtag_scan_mem.sv
hw/jtag_tap_sequencer.sv
hw/jtag_master_core.sv
tests/tb_jtag_master.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_jtag_master
FILELIST  := jtag_master.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/tb_jtag_master.sv
/* JTAG master testbench
   Random DR and IR scans checked against a TAP follower and a
   model of both scan memories */

`timescale 1ns/1ns
`default_nettype none
`include "jtag_master_config.svh"

module tb_jtag_master;
    localparam int NUM_RUNS    = 5;
    localparam int RUN_CYCLES  = 8 * 8 * `JM_MEM_BYTES + 400;  // 1-bit words are worst
    localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 1500) * 100;
    localparam int TOTAL_BITS  = 8 * `JM_MEM_BYTES;

    logic        clk;
    logic        rst_sync;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic        tdo;
    logic        tck;
    logic        tdi;
    logic        tms;
    logic        sen;
    logic        sld;

    logic [31:0] rng_state;
    logic [31:0] tdo_state;
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_err0;
    jtag_tap_pkg::tap_state_t fstate;  // TAP follower
    int          high_run;
    int          walks;
    int          last_walk;
    int          shift_dr_cnt;
    int          shift_ir_cnt;
    int          sld_cnt;
    logic        tdi_q [$];
    logic        tdo_q [$];
    logic        out_bits [TOTAL_BITS];

    jtag_master_core dut0 (
        .JTAG_CLK(clk), .RST_SYNC(rst_sync), .bus_add(bus_add),
        .bus_data_in(bus_data_in), .bus_rd(bus_rd), .bus_wr(bus_wr),
        .bus_data_out(bus_data_out), .tdo(tdo), .tck(tck), .tdi(tdi),
        .tms(tms), .sen(sen), .sld(sld)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic jtag_tap_pkg::tap_state_t tap_next(
        input jtag_tap_pkg::tap_state_t s, input logic m);
        case (s)
            jtag_tap_pkg::TEST_LOGIC_RESET: return m ? s : jtag_tap_pkg::RUN_TEST_IDLE;
            jtag_tap_pkg::RUN_TEST_IDLE:    return m ? jtag_tap_pkg::SELECT_DR_SCAN : s;
            jtag_tap_pkg::SELECT_DR_SCAN:
                return m ? jtag_tap_pkg::SELECT_IR_SCAN : jtag_tap_pkg::CAPTURE_DR;
            jtag_tap_pkg::CAPTURE_DR, jtag_tap_pkg::SHIFT_DR:
                return m ? jtag_tap_pkg::EXIT1_DR : jtag_tap_pkg::SHIFT_DR;
            jtag_tap_pkg::EXIT1_DR:         return jtag_tap_pkg::UPDATE_DR;
            jtag_tap_pkg::SELECT_IR_SCAN:
                return m ? jtag_tap_pkg::TEST_LOGIC_RESET : jtag_tap_pkg::CAPTURE_IR;
            jtag_tap_pkg::CAPTURE_IR, jtag_tap_pkg::SHIFT_IR:
                return m ? jtag_tap_pkg::EXIT1_IR : jtag_tap_pkg::SHIFT_IR;
            jtag_tap_pkg::EXIT1_IR:         return jtag_tap_pkg::UPDATE_IR;
            default:  // Both Update states
                return m ? jtag_tap_pkg::SELECT_DR_SCAN : jtag_tap_pkg::RUN_TEST_IDLE;
        endcase
    endfunction

    // Follower advances on every rising tck
    always @(posedge tck)
    begin
        if (!rst_sync)
        begin
            if (fstate == jtag_tap_pkg::SHIFT_DR || fstate == jtag_tap_pkg::SHIFT_IR)
            begin
                tdi_q.push_back(tdi);
                tdo_q.push_back(tdo);
                if (fstate == jtag_tap_pkg::SHIFT_DR)
                    shift_dr_cnt++;
                else
                    shift_ir_cnt++;
            end
            if ((fstate == jtag_tap_pkg::EXIT1_DR || fstate == jtag_tap_pkg::EXIT1_IR) && !tms)
            begin
                $display("TMS low in Exit1 would enter a Pause state");
                errors++;
            end
            if (tms)
                high_run++;
            else
            begin
                if (fstate == jtag_tap_pkg::TEST_LOGIC_RESET)
                begin
                    last_walk = high_run;
                    walks++;
                end
                high_run = 0;
            end
            fstate = tap_next(fstate, tms);
        end
    end

    always @(negedge clk)
    begin
        if (sld === 1'b1)
            sld_cnt++;
    end

    always @(negedge clk)
    begin
        tdo_state = xorshift32(tdo_state);
        tdo <= tdo_state[7];
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    task report_mismatch(input string name, input int exp, input int act);
        $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task begin_test();
        test_err0 = errors;
    endtask

    task end_test(input string name);
        tests++;
        if (errors == test_err0)
            $display("PASS %s", name);
        else
        begin
            $display("FAIL %s", name);
            failed_tests++;
        end
    endtask

    task bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge clk);
        bus_wr      = 1'b0;
    endtask

    task bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(negedge clk);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge clk);
        bus_rd  = 1'b0;
        data    = bus_data_out;
    endtask

    task expect_read(input string name, input logic [15:0] addr, input logic [7:0] exp);
        logic [7:0] d;
        bus_read(addr, d);
        if (d !== exp)
            report_mismatch(name, exp, d);
    endtask

    task wait_walk(input int walks0);
        int n;
        n = 0;
        while (walks == walks0 && n < 60)
        begin
            @(negedge clk);
            n++;
        end
        if (walks == walks0)
        begin
            $display("Reset walk never reached Run-Test/Idle");
            errors++;
        end
        else if (last_walk < `JM_RESET_TCKS)
            report_mismatch("reset_walk_tms_high", `JM_RESET_TCKS, last_walk);
        repeat (4) @(negedge clk);
    endtask

    task check_defaults(input string name);
        expect_read({name, "_version"}, 16'd0, 8'(`JM_VERSION));
        expect_read({name, "_done"}, 16'd1, 8'd1);
        expect_read({name, "_bits_lo"}, 16'd3, 8'(TOTAL_BITS));
        expect_read({name, "_bits_hi"}, 16'd4, 8'(TOTAL_BITS >> 8));
        expect_read({name, "_words_lo"}, 16'd9, 8'd1);
        expect_read({name, "_words_hi"}, 16'd10, 8'd0);
        expect_read({name, "_op_lo"}, 16'd11, 8'd0);
        expect_read({name, "_op_hi"}, 16'd12, 8'd0);
        for (int a = 5; a <= 8; a++)
            expect_read({name, "_spare"}, 16'(a), 8'd0);
        expect_read({name, "_size_lo"}, 16'd14, 8'(`JM_MEM_BYTES));
        expect_read({name, "_size_hi"}, 16'd15, 8'(`JM_MEM_BYTES >> 8));
    endtask

    task run_scan(input string name, input logic [15:0] op, input int bits, input int words);
        logic [7:0] b;
        logic [7:0] mask;
        logic [7:0] exp;
        int         total;
        int         n;
        bit         is_dr;
        begin_test();
        total = bits * words;
        is_dr = (op == 16'd1);
        for (int j = 0; j < `JM_MEM_BYTES; j++)
        begin
            b = next_rand();
            for (int i = 0; i < 8; i++)
                out_bits[8*j + i] = b[7-i];  // MSB goes first
            bus_write(16'(16 + j), b);
        end
        bus_write(16'd3, 8'(bits));
        bus_write(16'd4, 8'(bits >> 8));
        bus_write(16'd9, 8'(words));
        bus_write(16'd10, 8'(words >> 8));
        bus_write(16'd11, op[7:0]);
        bus_write(16'd12, op[15:8]);
        tdi_q.delete();
        tdo_q.delete();
        shift_dr_cnt = 0;
        shift_ir_cnt = 0;
        sld_cnt      = 0;
        bus_write(16'd1, 8'd0);
        expect_read({name, "_done_after_start"}, 16'd1, 8'd0);
        n = 0;
        b = 8'd0;
        while (b[0] !== 1'b1 && n < RUN_CYCLES)
        begin
            bus_read(16'd1, b);
            n += 2;
        end
        if (b[0] !== 1'b1)
        begin
            $display("Run %s did not set the done flag in time", name);
            errors++;
        end
        repeat (8) @(negedge clk);
        if (sld_cnt != 1)
            report_mismatch({name, "_sld_pulses"}, 1, sld_cnt);
        if (sen !== 1'b0)
            report_mismatch({name, "_sen_idle"}, 0, sen);
        if (shift_dr_cnt != (is_dr ? total : 0))
            report_mismatch({name, "_shift_dr"}, is_dr ? total : 0, shift_dr_cnt);
        if (shift_ir_cnt != (is_dr ? 0 : total))
            report_mismatch({name, "_shift_ir"}, is_dr ? 0 : total, shift_ir_cnt);
        if (tdi_q.size() != total)
            report_mismatch({name, "_tdi_len"}, total, tdi_q.size());
        else
        begin
            for (int k = 0; k < total; k++)
            begin
                if (tdi_q[k] !== out_bits[k])
                begin
                    report_mismatch({name, "_tdi_bit"}, out_bits[k], tdi_q[k]);
                    break;
                end
            end
        end
        // Only bits written by this run are known
        for (int j = 0; j * 8 < total && j * 8 < tdo_q.size(); j++)
        begin
            bus_read(16'(16 + `JM_MEM_BYTES + j), b);
            mask = '0;
            exp  = '0;
            for (int i = 0; i < 8; i++)
            begin
                if (8*j + i < total && 8*j + i < tdo_q.size())
                begin
                    mask[7-i] = 1'b1;
                    exp[7-i]  = tdo_q[8*j + i];
                end
            end
            if ((b & mask) !== exp)
                report_mismatch({name, "_capture"}, exp, b & mask);
        end
        end_test(name);
    endtask

    task random_counts(output int bits, output int words);
        bits  = 1 + int'(next_rand() % 32);
        words = 1 + int'(next_rand() % (TOTAL_BITS / bits));
    endtask

    initial
    begin
        logic [7:0]  wvals [3:12];
        logic [15:0] op;
        int          bits;
        int          words;
        clk = 1'b0;
        rst_sync = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        tdo = 1'b0;
        rng_state = 32'hff69_5cb9;
        tdo_state = xorshift32(32'hff69_5cb9 ^ 32'h5a5a_5a5a);
        errors = 0;
        tests = 0;
        failed_tests = 0;
        fstate = jtag_tap_pkg::TEST_LOGIC_RESET;
        high_run = 0;
        walks = 0;
        last_walk = 0;
        sld_cnt = 0;
        repeat (8) @(negedge clk);
        rst_sync = 1'b0;

        begin_test();
        wait_walk(0);
        check_defaults("reset");
        end_test("reset_defaults");

        begin_test();
        for (int a = 3; a <= 12; a++)
        begin
            wvals[a] = next_rand();
            bus_write(16'(a), wvals[a]);
        end
        for (int a = 3; a <= 12; a++)
            expect_read("reg_readback", 16'(a), wvals[a]);
        bus_write(16'd0, 8'd0);
        wait_walk(walks);
        check_defaults("soft_reset");
        end_test("registers_and_soft_reset");

        for (int r = 0; r < 3; r++)
        begin
            random_counts(bits, words);
            run_scan($sformatf("dr_scan_%0d", r), 16'd1, bits, words);
        end
        random_counts(bits, words);
        run_scan("ir_scan_op0", 16'd0, bits, words);
        op = next_rand();
        if (op < 16'd2)
            op = op + 16'd2;
        random_counts(bits, words);
        run_scan("ir_scan_op_other", op, bits, words);

        $display("Tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/jtag_master_core.sv
/* JTAG scan master top
   Register block, scan memories and TAP sequencer on one clock */

`timescale 1ns/1ns
`default_nettype none

module jtag_master_core (
    input  wire                          JTAG_CLK,
    input  wire                          RST_SYNC,
    input  wire jtag_bus_pkg::bus_addr_t bus_add,
    input  wire jtag_bus_pkg::bus_byte_t bus_data_in,
    input  wire                          bus_rd,
    input  wire                          bus_wr,
    output wire jtag_bus_pkg::bus_byte_t bus_data_out,
    input  wire                          tdo,
    output wire                          tck,
    output wire                          tdi,
    output wire                          tms,
    output wire                          sen,
    output wire                          sld
);
    wire                              start;
    wire                              soft_rst;
    wire                              done;
    wire jtag_bus_pkg::bit_count_t    bit_count;
    wire jtag_bus_pkg::word_count_t   word_count;
    wire jtag_tap_pkg::op_code_t      op_code;
    wire jtag_bus_pkg::bus_byte_t     mem_rd_data;
    wire                              mem_rd_hit;
    wire jtag_tap_pkg::mem_bit_addr_t bit_addr;
    wire                              capture_en;
    wire                              shift_bit;

    jtag_master_regs regs0 (
        .JTAG_CLK     (JTAG_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_hit   (mem_rd_hit),
        .done         (done),
        .start        (start),
        .soft_rst     (soft_rst),
        .bit_count    (bit_count),
        .word_count   (word_count),
        .op_code      (op_code)
    );

    jtag_scan_mem mem0 (
        .JTAG_CLK     (JTAG_CLK),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_hit   (mem_rd_hit),
        .bit_addr     (bit_addr),
        .capture_en   (capture_en),
        .tdo          (tdo),
        .shift_bit    (shift_bit)
    );

    jtag_tap_sequencer seq0 (
        .JTAG_CLK     (JTAG_CLK),
        .RST_SYNC     (RST_SYNC),
        .soft_rst     (soft_rst),
        .start        (start),
        .bit_count    (bit_count),
        .word_count   (word_count),
        .op_code      (op_code),
        .bit_addr     (bit_addr),
        .shift_bit    (shift_bit),
        .capture_en   (capture_en),
        .done         (done),
        .tck          (tck),
        .tdi          (tdi),
        .tms          (tms),
        .sen          (sen),
        .sld          (sld)
    );

endmodule

`default_nettype wire

// File: hw/jtag_tap_sequencer.sv
/* JTAG TAP sequencer
   Walks the TAP through one DR or IR scan per word, drives TMS, TDI
   and the gated TCK, and flags the end of a run or of the reset walk */

`timescale 1ns/1ns
`default_nettype none
`include "jtag_master_config.svh"

module jtag_tap_sequencer (
    input  wire                              JTAG_CLK,
    input  wire                              RST_SYNC,
    input  wire                              soft_rst,
    input  wire                              start,
    input  wire jtag_bus_pkg::bit_count_t    bit_count,
    input  wire jtag_bus_pkg::word_count_t   word_count,
    input  wire jtag_tap_pkg::op_code_t      op_code,
    output jtag_tap_pkg::mem_bit_addr_t      bit_addr,
    input  wire                              shift_bit,
    output logic                             capture_en,
    output logic                             done,
    output wire                              tck,
    output logic                             tdi,
    output logic                             tms,
    output logic                             sen,
    output logic                             sld
);
    localparam int RCNT_W = $clog2(`JM_RESET_TCKS + 1);
    localparam logic [RCNT_W-1:0] RESET_END = RCNT_W'(`JM_RESET_TCKS);

    jtag_tap_pkg::tap_state_t  state;
    jtag_tap_pkg::tap_state_t  next_state;
    logic                      rst;
    logic [RCNT_W-1:0]         reset_cnt;
    jtag_bus_pkg::bit_count_t  bit_cnt;
    jtag_bus_pkg::word_count_t word_cnt;
    logic                      in_shift;
    logic                      in_update;
    logic                      last_bit;
    logic                      last_word;
    logic                      go;
    logic                      sen_int;
    logic                      tms_next;
    logic [1:0]                sen_dly;

    assign rst       = RST_SYNC || soft_rst;  // Soft reset restarts the walk
    assign in_shift  = (state == jtag_tap_pkg::SHIFT_DR) || (state == jtag_tap_pkg::SHIFT_IR);
    assign in_update = (state == jtag_tap_pkg::UPDATE_DR) || (state == jtag_tap_pkg::UPDATE_IR);

    // A zero count behaves like one
    assign last_bit  = ({1'b0, bit_cnt} + 17'd1) >= {1'b0, bit_count};
    assign last_word = ({1'b0, word_cnt} + 17'd1) >= {1'b0, word_count};
    assign go        = start || (word_cnt != '0);  // Next word keeps sen high

    assign bit_addr   = jtag_tap_pkg::mem_bit_addr_t'(word_cnt * bit_count + bit_cnt);
    assign capture_en = in_shift;

    // Next state and the TMS value that takes the TAP there
    always_comb
    begin
        next_state = state;
        tms_next   = 1'b0;
        sen_int    = 1'b1;
        case (state)
            jtag_tap_pkg::TEST_LOGIC_RESET:
            begin
                if (reset_cnt == RESET_END)
                    next_state = jtag_tap_pkg::RUN_TEST_IDLE;
                else
                    tms_next = 1'b1;
            end
            jtag_tap_pkg::RUN_TEST_IDLE:
            begin
                sen_int = go;
                if (go)
                begin
                    next_state = jtag_tap_pkg::SELECT_DR_SCAN;
                    tms_next   = 1'b1;
                end
            end
            jtag_tap_pkg::SELECT_DR_SCAN:
            begin
                if (op_code == jtag_tap_pkg::OP_DR_SCAN)
                    next_state = jtag_tap_pkg::CAPTURE_DR;
                else
                begin
                    next_state = jtag_tap_pkg::SELECT_IR_SCAN;
                    tms_next   = 1'b1;
                end
            end
            jtag_tap_pkg::CAPTURE_DR: next_state = jtag_tap_pkg::SHIFT_DR;
            jtag_tap_pkg::SHIFT_DR:
            begin
                if (last_bit)
                begin
                    next_state = jtag_tap_pkg::EXIT1_DR;
                    tms_next   = 1'b1;
                end
            end
            jtag_tap_pkg::EXIT1_DR:
            begin
                next_state = jtag_tap_pkg::UPDATE_DR;
                tms_next   = 1'b1;
            end
            jtag_tap_pkg::UPDATE_DR:      next_state = jtag_tap_pkg::RUN_TEST_IDLE;
            jtag_tap_pkg::SELECT_IR_SCAN: next_state = jtag_tap_pkg::CAPTURE_IR;
            jtag_tap_pkg::CAPTURE_IR:     next_state = jtag_tap_pkg::SHIFT_IR;
            jtag_tap_pkg::SHIFT_IR:
            begin
                if (last_bit)
                begin
                    next_state = jtag_tap_pkg::EXIT1_IR;
                    tms_next   = 1'b1;
                end
            end
            jtag_tap_pkg::EXIT1_IR:
            begin
                next_state = jtag_tap_pkg::UPDATE_IR;
                tms_next   = 1'b1;
            end
            jtag_tap_pkg::UPDATE_IR:      next_state = jtag_tap_pkg::RUN_TEST_IDLE;
            default:
            begin
                next_state = jtag_tap_pkg::TEST_LOGIC_RESET;
                tms_next   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (rst)
        begin
            state     <= jtag_tap_pkg::TEST_LOGIC_RESET;
            reset_cnt <= '0;
            bit_cnt   <= '0;
            word_cnt  <= '0;
            done      <= 1'b0;
            sen_dly   <= '0;
            sld       <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            reset_cnt <= (state == jtag_tap_pkg::TEST_LOGIC_RESET) ?
                         reset_cnt + RCNT_W'(sen) : '0;  // Only clocks that reach the TAP
            bit_cnt   <= in_shift ? bit_cnt + 1'b1 : '0;
            if (in_update)
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            done <= ((state == jtag_tap_pkg::TEST_LOGIC_RESET) && (reset_cnt == RESET_END))
                    || (in_update && last_word);
            sen_dly <= {sen_dly[0], sen_int};
            sld     <= sen_dly[1] && !sen_dly[0];  // Falling edge of sen, two cycles late
        end
    end

    // Target samples on rising tck, so drive half a cycle ahead
    always_ff @(negedge JTAG_CLK)
    begin
        if (rst)
        begin
            tms <= 1'b1;
            sen <= 1'b0;
            tdi <= 1'b0;
        end
        else
        begin
            tms <= tms_next;
            sen <= sen_int;
            tdi <= in_shift && shift_bit;
        end
    end

    assign tck = JTAG_CLK & sen;  // sen only moves while the clock is low

endmodule

`default_nettype wire

// File: hw/jtag_scan_mem.sv
/* JTAG scan memories
   Shift-out bits written bytewise from the bus, capture bits written
   from TDO and read back bytewise, MSB of each byte first */

`timescale 1ns/1ns
`default_nettype none
`include "jtag_master_config.svh"

module jtag_scan_mem (
    input  wire                              JTAG_CLK,
    input  wire jtag_bus_pkg::bus_addr_t     bus_add,
    input  wire jtag_bus_pkg::bus_byte_t     bus_data_in,
    input  wire                              bus_rd,
    input  wire                              bus_wr,
    output jtag_bus_pkg::bus_byte_t          mem_rd_data,
    output logic                             mem_rd_hit,
    input  wire jtag_tap_pkg::mem_bit_addr_t bit_addr,
    input  wire                              capture_en,
    input  wire                              tdo,
    output logic                             shift_bit
);
    localparam int BYTE_W = $clog2(`JM_MEM_BYTES);
    localparam jtag_bus_pkg::bus_addr_t OUT_BASE = jtag_bus_pkg::ADDR_MEM_BASE;
    localparam jtag_bus_pkg::bus_addr_t CAP_BASE = OUT_BASE + `JM_MEM_BYTES;
    localparam jtag_bus_pkg::bus_addr_t CAP_END  = CAP_BASE + `JM_MEM_BYTES;

    // Bytes are stored bit reversed so bit k sits at [k/8][k%8]
    jtag_bus_pkg::bus_byte_t out_mem [`JM_MEM_BYTES];
    jtag_bus_pkg::bus_byte_t cap_mem [`JM_MEM_BYTES];

    logic                    out_hit;
    logic                    cap_hit;
    jtag_bus_pkg::bus_addr_t out_off;
    jtag_bus_pkg::bus_addr_t cap_off;
    logic [BYTE_W-1:0]       bit_byte;
    logic [2:0]              bit_pos;
    jtag_bus_pkg::bus_byte_t wr_rev;
    jtag_bus_pkg::bus_byte_t cap_rev;

    assign out_hit = (bus_add >= OUT_BASE) && (bus_add < CAP_BASE);
    assign cap_hit = (bus_add >= CAP_BASE) && (bus_add < CAP_END);
    assign out_off = bus_add - OUT_BASE;
    assign cap_off = bus_add - CAP_BASE;

    assign {bit_byte, bit_pos} = bit_addr;
    assign shift_bit = out_mem[bit_byte][bit_pos];

    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            wr_rev[i]  = bus_data_in[7-i];
            cap_rev[i] = cap_mem[cap_off[BYTE_W-1:0]][7-i];
        end
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (bus_wr && out_hit)
            out_mem[out_off[BYTE_W-1:0]] <= wr_rev;
        if (capture_en)
            cap_mem[bit_byte][bit_pos] <= tdo;
    end

    // Shift-out window reads back as zero
    always_ff @(posedge JTAG_CLK)
    begin
        if (bus_rd)
        begin
            mem_rd_hit  <= out_hit || cap_hit;
            mem_rd_data <= cap_hit ? cap_rev : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/jtag_master_regs.sv
/* JTAG master register block
   Holds the scan configuration, turns writes to the reset and start
   addresses into pulses, keeps the done flag and muxes bus read data */

`timescale 1ns/1ns
`default_nettype none
`include "jtag_master_config.svh"

module jtag_master_regs (
    input  wire                              JTAG_CLK,
    input  wire                              RST_SYNC,
    input  wire jtag_bus_pkg::bus_addr_t     bus_add,
    input  wire jtag_bus_pkg::bus_byte_t     bus_data_in,
    input  wire                              bus_rd,
    input  wire                              bus_wr,
    output jtag_bus_pkg::bus_byte_t          bus_data_out,
    input  wire jtag_bus_pkg::bus_byte_t     mem_rd_data,
    input  wire                              mem_rd_hit,
    input  wire                              done,
    output logic                             start,
    output logic                             soft_rst,
    output jtag_bus_pkg::bit_count_t         bit_count,
    output jtag_bus_pkg::word_count_t        word_count,
    output jtag_tap_pkg::op_code_t           op_code
);
    localparam logic [15:0] DEF_BITS  = 16'(8 * `JM_MEM_BYTES);
    localparam logic [15:0] MEM_SIZE  = 16'(`JM_MEM_BYTES);
    localparam logic [7:0]  VERSION   = 8'(`JM_VERSION);

    jtag_bus_pkg::bus_byte_t reg_file [16];
    jtag_bus_pkg::bus_byte_t rd_data;
    logic                    reg_hit;
    logic                    reset_req;
    logic                    start_req;
    logic                    done_flag;

    assign reg_hit   = (bus_add < 16);
    assign reset_req = bus_wr && (bus_add == jtag_bus_pkg::ADDR_RESET);
    assign start_req = bus_wr && (bus_add == jtag_bus_pkg::ADDR_START);

    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC || reset_req)
        begin
            for (int i = 0; i < 16; i++)
            begin
                reg_file[i] <= '0;
            end
            reg_file[jtag_bus_pkg::ADDR_BITS_LO[3:0]]  <= DEF_BITS[7:0];
            reg_file[jtag_bus_pkg::ADDR_BITS_HI[3:0]]  <= DEF_BITS[15:8];
            reg_file[jtag_bus_pkg::ADDR_WORDS_LO[3:0]] <= 8'd1;
            reg_file[jtag_bus_pkg::ADDR_OP_LO[3:0]]    <= jtag_tap_pkg::OP_IR_SCAN[7:0];
            reg_file[jtag_bus_pkg::ADDR_OP_HI[3:0]]    <= jtag_tap_pkg::OP_IR_SCAN[15:8];
        end
        else if (bus_wr && reg_hit)
        begin
            reg_file[bus_add[3:0]] <= bus_data_in;
        end
    end

    // Pulses land one cycle after the write
    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC)
        begin
            start    <= 1'b0;
            soft_rst <= 1'b0;
        end
        else
        begin
            start    <= start_req;
            soft_rst <= reset_req;
        end
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC || reset_req || start_req)
            done_flag <= 1'b0;  // Cleared as soon as a run is requested
        else if (done)
            done_flag <= 1'b1;
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (bus_rd)
        begin
            case (bus_add)
                16'd0:   rd_data <= VERSION;
                16'd1:   rd_data <= {7'b0, done_flag};
                16'd14:  rd_data <= MEM_SIZE[7:0];
                16'd15:  rd_data <= MEM_SIZE[15:8];
                default: rd_data <= reg_hit ? reg_file[bus_add[3:0]] : '0;
            endcase
        end
    end

    assign bus_data_out = mem_rd_hit ? mem_rd_data : rd_data;

    assign bit_count  = {reg_file[jtag_bus_pkg::ADDR_BITS_HI[3:0]],
                         reg_file[jtag_bus_pkg::ADDR_BITS_LO[3:0]]};
    assign word_count = {reg_file[jtag_bus_pkg::ADDR_WORDS_HI[3:0]],
                         reg_file[jtag_bus_pkg::ADDR_WORDS_LO[3:0]]};
    assign op_code    = {reg_file[jtag_bus_pkg::ADDR_OP_HI[3:0]],
                         reg_file[jtag_bus_pkg::ADDR_OP_LO[3:0]]};

endmodule

`default_nettype wire

// File: hw/jtag_tap_pkg.sv
/* JTAG TAP types
   TAP controller states, scan op codes and the bit address of
   the scan memories */

`default_nettype none
`include "jtag_master_config.svh"

package jtag_tap_pkg;

    // Pause and Exit2 states are never used
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR_SCAN,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        UPDATE_DR,
        SELECT_IR_SCAN,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        UPDATE_IR
    } tap_state_t;

    typedef logic [15:0] op_code_t;

    localparam op_code_t OP_IR_SCAN = 16'd0;
    localparam op_code_t OP_DR_SCAN = 16'd1;  // Anything else scans IR

    typedef logic [$clog2(8 * `JM_MEM_BYTES)-1:0] mem_bit_addr_t;

endpackage

`default_nettype wire

// File: hw/jtag_bus_pkg.sv
/* JTAG master bus types
   Address and data types plus the register map of the byte bus */

`default_nettype none
`include "jtag_master_config.svh"

package jtag_bus_pkg;

    typedef logic [`JM_ABUSWIDTH-1:0] bus_addr_t;
    typedef logic [7:0]               bus_byte_t;
    typedef logic [15:0]              bit_count_t;
    typedef logic [15:0]              word_count_t;

    localparam bus_addr_t ADDR_RESET    = 0;  // Write only, soft reset
    localparam bus_addr_t ADDR_START    = 1;
    localparam bus_addr_t ADDR_BITS_LO  = 3;
    localparam bus_addr_t ADDR_BITS_HI  = 4;
    localparam bus_addr_t ADDR_WORDS_LO = 9;
    localparam bus_addr_t ADDR_WORDS_HI = 10;
    localparam bus_addr_t ADDR_OP_LO    = 11;
    localparam bus_addr_t ADDR_OP_HI    = 12;
    // Shift-out window, capture window follows
    localparam bus_addr_t ADDR_MEM_BASE = 16;

endpackage

`default_nettype wire

// File: hw/jtag_master_config.svh
/* JTAG master configuration
   Bus width, memory size, version and reset walk length */

`ifndef JTAG_MASTER_CONFIG_SVH
`define JTAG_MASTER_CONFIG_SVH

`define JM_ABUSWIDTH 16

// Bytes per scan memory, 8 bits each
`define JM_MEM_BYTES 16

`define JM_VERSION 1

`define JM_RESET_TCKS 5

`endif
